// File: dualPortRam.sv
`timescale 1ns/1ps
`default_nettype none

module dualPortRam #(
    parameter int Width = 32,
    parameter int Depth = 32
) (
    input  wire logic                     CLK,
    input  wire logic                     WrEn,
    input  wire logic [$clog2(Depth)-1:0] WrAddr,
    input  wire logic [Width-1:0]         WrData,
    input  wire logic [$clog2(Depth)-1:0] RdAddr,
    output logic      [Width-1:0]         RdData
);

    logic [Width-1:0] mem [Depth];

    always_ff @(posedge CLK) begin
        if (WrEn) begin
            mem[WrAddr] <= WrData;
        end
        RdData <= mem[RdAddr];  // Returns old data on a same-address write
    end

endmodule

`default_nettype wire

// File: flist.f
reorderPkg.sv
dualPortRam.sv
reorderInput.sv
reorderBuffer.sv
reorderOutput.sv
reorderTop.sv
tbReorderTop.sv

// File: reorderBuffer.sv
`timescale 1ns/1ps
`default_nettype none

module reorderBuffer import reorderPkg::*; (
    input  wire logic                    CLK,
    input  wire laneAddrT [NumLanes-1:0] WrAddr,
    input  wire dataT                    WrData,
    input  wire laneMaskT                WrEn,
    input  wire tagT                     RdTag,
    input  wire countT                   RdIndex,
    output dwT                           RdData
);

    laneAddrT rdAddr;
    laneIdxT  rdLane;
    laneIdxT  rLane;                 // Lane of the read in flight
    dwT       laneData [NumLanes];

    assign rdLane = laneIdxT'(RdIndex);   // Index modulo lane count
    assign rdAddr = (laneAddrT'(RdTag) << StrideWidth)
                  + laneAddrT'(RdIndex >> $bits(laneIdxT));

    for (genvar i = 0; i < NumLanes; i++) begin : gLane
        dualPortRam #(
            .Width ($bits(dwT)),
            .Depth (NumTags << StrideWidth)
        ) laneRam (
            .CLK    (CLK),
            .WrEn   (WrEn[i]),
            .WrAddr (WrAddr[i]),
            .WrData (WrData[i*$bits(dwT) +: $bits(dwT)]),
            .RdAddr (rdAddr),
            .RdData (laneData[i])
        );
    end

    always_ff @(posedge CLK) begin
        rLane <= rdLane;
    end

    assign RdData = laneData[rLane];

endmodule

`default_nettype wire

// File: reorderInput.sv
`timescale 1ns/1ps
`default_nettype none

module reorderInput import reorderPkg::*; (
    input  wire logic               CLK,
    input  wire logic               RST,
    input  wire logic               Valid,
    input  wire dataT               Data,
    input  wire laneMaskT           DataEn,
    input  wire logic               DataStartFlag,
    input  wire laneIdxT            DataStartOffset,
    input  wire logic               Done,
    input  wire logic               Err,
    input  wire tagT                Tag,
    input  wire tagMapT             TagClear,
    output tagMapT                  TagFinish,
    output laneAddrT [NumLanes-1:0] StoredAddr,
    output dataT                    StoredData,
    output laneMaskT                StoredEn,
    output logic                    PktValid,
    output tagT                     PktTag,
    output countT                   PktWords,
    output logic                    PktErr
);

    laneIdxT            startOff;
    laneMaskT           inEn;          // Enables aligned down to lane 0
    dataT               inData;
    logic [5:0]         valid;         // Bit k is the beat seen k+1 cycles ago
    logic [4:0]         doneD;
    logic [5:0]         errD;
    tagT                tagD [6];
    dataT               dataD [5];
    laneMaskT           enD [3];
    countT              beatCnt [2];
    tagMapT             tagValid;      // Tag has seen data since its last clear
    logic [2:0]         cntValid;
    logic               useCurrCnt;
    logic               usePrevCnt;
    countT              ramCount;
    countT              baseCount;
    countT              rCount;
    countT              rPrevCount;
    laneIdxT            rShift;
    laneIdxT            shiftD [2];
    laneMaskT           rEnRot;
    laneMaskT           enRotD;
    logic               useCurrPos;
    logic               usePrevPos;
    posT [NumLanes-1:0] ramPos;
    posT [NumLanes-1:0] basePos;
    posT [NumLanes-1:0] rPos;
    posT [NumLanes-1:0] rPrevPos;
    posT [NumLanes-1:0] rPosNow;
    countT              wordsD [3];
    tagMapT             rFinish;

    assign startOff = DataStartFlag ? DataStartOffset : '0;
    assign inEn     = Valid ? laneMaskT'(DataEn >> startOff) : '0;
    assign inData   = Data >> (startOff * $bits(dwT));

    // Bypass covers RAM writes that are still in flight
    assign baseCount = useCurrCnt  ? rCount :
                       usePrevCnt  ? rPrevCount :
                       cntValid[0] ? ramCount : '0;
    assign basePos   = useCurrPos  ? rPos :
                       usePrevPos  ? rPrevPos :
                       cntValid[2] ? ramPos : '0;

    assign TagFinish = rFinish;
    assign PktValid  = valid[5];
    assign PktTag    = tagD[5];
    assign PktWords  = wordsD[2];
    assign PktErr    = errD[5];

    always_ff @(posedge CLK) begin
        if (RST) begin
            valid    <= '0;
            tagValid <= '0;
            enD      <= '{default: '0};
            rEnRot   <= '0;
            enRotD   <= '0;
            StoredEn <= '0;
            rFinish  <= '0;
        end else begin
            valid    <= {valid[4:0], Valid};
            tagValid <= (tagValid | (tagMapT'(valid[0]) << tagD[0])) & ~TagClear;
            enD[0]   <= inEn;
            enD[1]   <= enD[0];
            enD[2]   <= enD[1];
            for (int j = 0; j < NumLanes; j++) begin
                rEnRot[j] <= enD[2][laneIdxT'(j - rShift)];  // Rotate up by old count
            end
            enRotD   <= rEnRot;
            StoredEn <= enRotD;
            rFinish  <= tagMapT'(valid[4] & (doneD[4] | errD[4])) << tagD[4];
        end
    end

    always_ff @(posedge CLK) begin
        tagD[0] <= Tag;
        for (int i = 1; i < 6; i++) begin
            tagD[i] <= tagD[i-1];
        end
        dataD[0] <= inData;
        for (int i = 1; i < 5; i++) begin
            dataD[i] <= dataD[i-1];
        end
        doneD      <= {doneD[3:0], Done};
        errD       <= {errD[4:0], Err};
        beatCnt[0] <= countT'($countones(inEn));
        beatCnt[1] <= beatCnt[0];

        // Running DW count per tag
        cntValid   <= {cntValid[1:0], tagValid[tagD[0]]};
        useCurrCnt <= valid[1] && (tagD[1] == tagD[0]);
        usePrevCnt <= valid[2] && (tagD[2] == tagD[0]);
        rShift     <= laneIdxT'(baseCount);
        rCount     <= baseCount + beatCnt[1];
        rPrevCount <= rCount;

        // Per-lane write positions
        shiftD[0]  <= rShift;
        shiftD[1]  <= shiftD[0];
        useCurrPos <= valid[3] && (tagD[3] == tagD[2]);
        usePrevPos <= valid[4] && (tagD[4] == tagD[2]);
        rPosNow    <= basePos;
        for (int i = 0; i < NumLanes; i++) begin
            rPos[i] <= basePos[i] + posT'(rEnRot[i]);
        end
        rPrevPos   <= rPos;

        for (int j = 0; j < NumLanes; j++) begin
            StoredAddr[j] <= {tagD[4], rPosNow[j]};
            StoredData[j*$bits(dwT) +: $bits(dwT)] <=
                dataD[4][laneIdxT'(j - shiftD[1]) * $bits(dwT) +: $bits(dwT)];
        end
        wordsD[0] <= rCount;
        wordsD[1] <= wordsD[0];
        wordsD[2] <= wordsD[1];
    end

    dualPortRam #(
        .Width (CountWidth),
        .Depth (NumTags)
    ) countRam (
        .CLK    (CLK),
        .WrEn   (valid[2]),
        .WrAddr (tagD[2]),
        .WrData (rCount),
        .RdAddr (tagD[0]),
        .RdData (ramCount)
    );

    dualPortRam #(
        .Width (NumLanes * StrideWidth),
        .Depth (NumTags)
    ) posRam (
        .CLK    (CLK),
        .WrEn   (valid[4]),
        .WrAddr (tagD[4]),
        .WrData (rPos),
        .RdAddr (tagD[2]),
        .RdData (ramPos)
    );

    // Every beat carries payload
    assert property (@(posedge CLK) disable iff (RST) Valid |-> DataEn != '0)
        else $error("Completion beat with no enabled DWs");

    // Tag never overflows its buffer stride
    assert property (@(posedge CLK) disable iff (RST)
        valid[2] |-> rCount <= countT'(NumLanes << StrideWidth))
        else $error("Tag DW count above buffer capacity");

endmodule

`default_nettype wire

// File: reorderOutput.sv
`timescale 1ns/1ps
`default_nettype none

module reorderOutput import reorderPkg::*; (
    input  wire logic   CLK,
    input  wire logic   RST,
    input  wire tagMapT TagFinish,
    input  wire logic   PktValid,
    input  wire tagT    PktTag,
    input  wire countT  PktWords,
    input  wire logic   PktErr,
    input  wire dwT     RdData,
    input  wire logic   CreditReturn,
    output tagT         RdTag,
    output countT       RdIndex,
    output tagMapT      TagClear,
    output logic        OutValid,
    output dwT          OutData,
    output tagT         OutTag,
    output logic        OutLast,
    output logic        OutErr
);

    drainStateT state;
    tagMapT     finished;            // Tags ready to drain
    countT      wordTable [NumTags];
    tagMapT     errTable;
    tagT        head;                // Next tag in order
    countT      idx;
    creditT     credit;
    logic       spend;
    logic       lastIdx;
    tagMapT     clearMap;

    assign RdTag    = head;
    assign RdIndex  = idx;
    assign lastIdx  = (idx == wordTable[head] - countT'(1));
    assign spend    = (credit != '0) && (state == Stream || state == ErrBeat);
    assign clearMap = (state == Clear) ? (tagMapT'(1) << head) : '0;
    assign OutData  = OutErr ? '0 : RdData;  // Error beat drops stored payload

    always_ff @(posedge CLK) begin
        if (PktValid) begin
            wordTable[PktTag] <= PktWords;   // Last beat leaves the final count
            errTable[PktTag]  <= PktErr;
        end
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            state    <= Idle;
            finished <= '0;
            head     <= '0;
            idx      <= '0;
            credit   <= creditT'(CreditMax);
            TagClear <= '0;
            OutValid <= 1'b0;
            OutTag   <= '0;
            OutLast  <= 1'b0;
            OutErr   <= 1'b0;
        end else begin
            finished <= (finished | TagFinish) & ~clearMap;
            credit   <= credit - creditT'(spend) + creditT'(CreditReturn);
            TagClear <= clearMap;
            OutValid <= spend;               // Read data returns next cycle
            OutTag   <= head;
            OutLast  <= spend && (state == ErrBeat || lastIdx);
            OutErr   <= spend && (state == ErrBeat);
            case (state)
                Idle: begin
                    if (finished[head]) begin
                        idx   <= '0;
                        state <= errTable[head] ? ErrBeat : Stream;
                    end
                end
                Stream: begin
                    if (spend) begin
                        idx <= idx + countT'(1);
                        if (lastIdx) begin
                            state <= Clear;
                        end
                    end
                end
                ErrBeat: begin
                    if (spend) begin
                        state <= Clear;
                    end
                end
                default: begin
                    head  <= head + tagT'(1);    // Wraps after tag 7
                    state <= Idle;
                end
            endcase
        end
    end

    // With no credit and none returned the counter stays at zero
    assert property (@(posedge CLK) disable iff (RST)
        ($past(credit) == '0 && !$past(CreditReturn)) |-> credit == '0)
        else $error("Credit counter wrapped below zero");

    assert property (@(posedge CLK) disable iff (RST) credit <= creditT'(CreditMax))
        else $error("Credit count above grant");

endmodule

`default_nettype wire

// File: reorderPkg.sv
`default_nettype none

package reorderPkg;

    localparam int DataWidth     = 128;                       // Completion beat width
    localparam int NumLanes      = 4;                         // DWs per beat
    localparam int TagWidth      = 3;
    localparam int NumTags       = 8;
    localparam int StrideWidth   = 2;                         // Up to 4 DWs per lane per tag
    localparam int LaneAddrWidth = TagWidth + StrideWidth;
    localparam int CountWidth    = 5;                         // Holds 0 to 16 DWs
    localparam int CreditMax     = 4;                         // Credits granted at reset

    typedef logic [DataWidth-1:0]          dataT;
    typedef logic [DataWidth/NumLanes-1:0] dwT;
    typedef logic [NumLanes-1:0]           laneMaskT;
    typedef logic [$clog2(NumLanes)-1:0]   laneIdxT;
    typedef logic [TagWidth-1:0]           tagT;
    typedef logic [NumTags-1:0]            tagMapT;
    typedef logic [CountWidth-1:0]         countT;
    typedef logic [StrideWidth-1:0]        posT;
    typedef logic [LaneAddrWidth-1:0]      laneAddrT;
    typedef logic [$clog2(CreditMax+1)-1:0] creditT;

    // Drain FSM of the output stage
    typedef enum logic [1:0] {
        Idle,
        Stream,
        ErrBeat,
        Clear
    } drainStateT;

endpackage

`default_nettype wire

// File: reorderTop.sv
`timescale 1ns/1ps
`default_nettype none

module reorderTop import reorderPkg::*; (
    input  wire logic     CLK,
    input  wire logic     RST,
    input  wire logic     Valid,
    input  wire dataT     Data,
    input  wire laneMaskT DataEn,
    input  wire logic     DataStartFlag,
    input  wire laneIdxT  DataStartOffset,
    input  wire logic     Done,
    input  wire logic     Err,
    input  wire tagT      Tag,
    input  wire logic     CreditReturn,
    output logic          OutValid,
    output dwT            OutData,
    output tagT           OutTag,
    output logic          OutLast,
    output logic          OutErr
);

    tagMapT                  tagFinish;
    tagMapT                  tagClear;
    laneAddrT [NumLanes-1:0] storedAddr;
    dataT                    storedData;
    laneMaskT                storedEn;
    logic                    pktValid;
    tagT                     pktTag;
    countT                   pktWords;
    logic                    pktErr;
    tagT                     rdTag;
    countT                   rdIndex;
    dwT                      rdData;

    reorderInput inputStage (
        .CLK             (CLK),
        .RST             (RST),
        .Valid           (Valid),
        .Data            (Data),
        .DataEn          (DataEn),
        .DataStartFlag   (DataStartFlag),
        .DataStartOffset (DataStartOffset),
        .Done            (Done),
        .Err             (Err),
        .Tag             (Tag),
        .TagClear        (tagClear),
        .TagFinish       (tagFinish),
        .StoredAddr      (storedAddr),
        .StoredData      (storedData),
        .StoredEn        (storedEn),
        .PktValid        (pktValid),
        .PktTag          (pktTag),
        .PktWords        (pktWords),
        .PktErr          (pktErr)
    );

    reorderBuffer bufferStage (
        .CLK     (CLK),
        .WrAddr  (storedAddr),
        .WrData  (storedData),
        .WrEn    (storedEn),
        .RdTag   (rdTag),
        .RdIndex (rdIndex),
        .RdData  (rdData)
    );

    reorderOutput outputStage (
        .CLK          (CLK),
        .RST          (RST),
        .TagFinish    (tagFinish),
        .PktValid     (pktValid),
        .PktTag       (pktTag),
        .PktWords     (pktWords),
        .PktErr       (pktErr),
        .RdData       (rdData),
        .CreditReturn (CreditReturn),
        .RdTag        (rdTag),
        .RdIndex      (rdIndex),
        .TagClear     (tagClear),
        .OutValid     (OutValid),
        .OutData      (OutData),
        .OutTag       (OutTag),
        .OutLast      (OutLast),
        .OutErr       (OutErr)
    );

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the reorder queue testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tbReorderTop \
    -f flist.f

./obj_dir/VtbReorderTop | tee sim.log

# Fails the script unless the testbench reported a pass
grep -q "Verification passed" sim.log

// File: tbReorderTop.sv
`timescale 1ns/1ps
`default_nettype none

module tbReorderTop import reorderPkg::*; ();

    localparam int NumRows   = 22;
    localparam int NumPasses = 2;

    // Fields are tag, start offset, DW count, Done and Err
    // A DW count of 0 marks an idle cycle
    localparam logic [9:0] StimTable [NumRows] = '{
        {3'd5, 2'd0, 3'd4, 1'b0, 1'b0},
        {3'd3, 2'd0, 3'd4, 1'b0, 1'b0},
        {3'd5, 2'd1, 3'd3, 1'b0, 1'b0},   // Same tag two cycles later
        {3'd5, 2'd0, 3'd4, 1'b0, 1'b0},   // Back to back
        {3'd2, 2'd0, 3'd2, 1'b0, 1'b0},
        {3'd2, 2'd2, 3'd2, 1'b1, 1'b0},
        {3'd7, 2'd3, 3'd1, 1'b0, 1'b0},
        {3'd0, 2'd0, 3'd0, 1'b0, 1'b0},
        {3'd5, 2'd0, 3'd1, 1'b1, 1'b0},
        {3'd0, 2'd0, 3'd3, 1'b1, 1'b0},
        {3'd6, 2'd0, 3'd4, 1'b0, 1'b0},
        {3'd3, 2'd1, 3'd2, 1'b0, 1'b1},   // Error ends tag 3
        {3'd7, 2'd0, 3'd4, 1'b0, 1'b0},
        {3'd6, 2'd0, 3'd4, 1'b0, 1'b0},   // Gap of 3 goes through the RAMs
        {3'd7, 2'd2, 3'd2, 1'b1, 1'b0},
        {3'd1, 2'd0, 3'd4, 1'b0, 1'b0},
        {3'd1, 2'd0, 3'd4, 1'b0, 1'b0},
        {3'd1, 2'd0, 3'd4, 1'b0, 1'b0},
        {3'd1, 2'd0, 3'd4, 1'b1, 1'b0},   // Full 16 DWs
        {3'd6, 2'd1, 3'd1, 1'b1, 1'b0},
        {3'd4, 2'd0, 3'd2, 1'b0, 1'b0},
        {3'd4, 2'd1, 3'd2, 1'b1, 1'b0}
    };

    // DWs each tag streams per pass, one beat for the error tag
    localparam int ExpWords [NumTags] = '{3, 16, 4, 1, 4, 12, 9, 7};

    logic        CLK = 1'b0;
    logic        RST;
    logic        Valid;
    dataT        Data;
    laneMaskT    DataEn;
    logic        DataStartFlag;
    laneIdxT     DataStartOffset;
    logic        Done;
    logic        Err;
    tagT         Tag;
    logic        CreditReturn = 1'b0;
    logic        OutValid;
    dwT          OutData;
    tagT         OutTag;
    logic        OutLast;
    logic        OutErr;

    dwT          expQ [NumTags][$];      // Expected DWs per tag in arrival order
    tagMapT      expErr;
    logic [31:0] dataRng;
    logic [31:0] creditRng = 32'd24;
    tagT         expHead = '0;
    int          wordsSeen;
    int          tagsDone;
    int          testsFailed;
    int          checkErrs;
    int          errsAtTagStart;
    int          beats;
    int          returned;
    int          owed;
    int          holdLeft;
    int          creditErrs;
    int          setupErrs;
    int          cycles;
    int          timeoutLimit;

    always #10 CLK = ~CLK;

    reorderTop i_dut (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic driveRow(input logic [9:0] row);
        tagT      t;
        int       off;
        int       cnt;
        dataT     d;
        laneMaskT en;
        t   = row[9:7];
        off = int'(row[6:5]);
        cnt = int'(row[4:2]);
        d   = '0;
        en  = '0;
        for (int lane = 0; lane < NumLanes; lane++) begin
            dataRng = xorshift(dataRng);
            d[lane*$bits(dwT) +: $bits(dwT)] = dataRng;  // Lanes outside the range are junk
            if (cnt != 0 && lane >= off && lane < off + cnt) begin
                en[lane] = 1'b1;
                expQ[t].push_back(dataRng);
            end
        end
        Valid           = (cnt != 0);
        Data            = d;
        DataEn          = en;
        DataStartFlag   = (off != 0);
        DataStartOffset = row[6:5];
        Done            = row[1];
        Err             = row[0];
        Tag             = t;
        if (row[0]) begin
            expErr[t] = 1'b1;
        end
    endtask

    task automatic applyTable;
        for (int i = 0; i < NumRows; i++) begin
            @(negedge CLK);
            driveRow(StimTable[i]);
        end
        @(negedge CLK);
        Valid = 1'b0;
        Done  = 1'b0;
        Err   = 1'b0;
    endtask

    task automatic finishTag;
        if (wordsSeen != ExpWords[expHead]) begin
            $display("Tag %0d streamed %0d DWs instead of %0d", expHead, wordsSeen,
                     ExpWords[expHead]);
            checkErrs++;
        end
        if (checkErrs != errsAtTagStart) begin
            testsFailed++;
        end
        $display("Tag %0d pass %0d: %0d DWs %s", expHead, tagsDone / NumTags + 1, wordsSeen,
                 (checkErrs == errsAtTagStart) ? "ok" : "FAILED");
        errsAtTagStart = checkErrs;
        wordsSeen      = 0;
        tagsDone++;
        expHead = expHead + tagT'(1);
    endtask

    task automatic checkBeat;
        dwT   exp;
        logic lastExp;
        if (OutTag != expHead) begin
            $display("ERROR OutTag: expected %h, got %h", expHead, OutTag);
            checkErrs++;
        end
        if (expErr[expHead]) begin
            if (OutErr !== 1'b1) begin
                $display("ERROR OutErr tag %0d: expected %h, got %h", expHead, 1'b1, OutErr);
                checkErrs++;
            end
            if (OutLast !== 1'b1) begin
                $display("ERROR OutLast tag %0d: expected %h, got %h", expHead, 1'b1, OutLast);
                checkErrs++;
            end
            if (OutData !== '0) begin
                $display("ERROR OutData tag %0d: expected %h, got %h", expHead, 32'h0, OutData);
                checkErrs++;
            end
            expQ[expHead].delete();  // Stored payload of an error tag is dropped
            wordsSeen++;
            finishTag();
        end else if (expQ[expHead].size() == 0) begin
            $display("Tag %0d sent a beat after all of its DWs were out", expHead);
            checkErrs++;
        end else begin
            exp     = expQ[expHead].pop_front();
            lastExp = (expQ[expHead].size() == 0);
            wordsSeen++;
            if (OutData !== exp) begin
                $display("ERROR OutData tag %0d: expected %h, got %h", expHead, exp, OutData);
                checkErrs++;
            end
            if (OutErr !== 1'b0) begin
                $display("ERROR OutErr tag %0d: expected %h, got %h", expHead, 1'b0, OutErr);
                checkErrs++;
            end
            if (OutLast !== lastExp) begin
                $display("ERROR OutLast tag %0d: expected %h, got %h", expHead, lastExp, OutLast);
                checkErrs++;
            end
            if (lastExp) begin
                finishTag();
            end
        end
    endtask

    always @(negedge CLK) begin
        if (!RST && OutValid) begin
            checkBeat();
        end
    end

    // Credit return with random hold-back streaks
    always @(negedge CLK) begin
        if (RST) begin
            CreditReturn = 1'b0;
        end else begin
            if (OutValid) begin
                beats++;
                owed++;
                // The return driven last cycle only lands after this beat was sent
                if (beats > CreditMax + returned - int'(CreditReturn)) begin
                    $display("%0d beats sent with only %0d credits returned", beats, returned);
                    creditErrs++;
                end
            end
            creditRng = xorshift(creditRng);
            if (holdLeft > 0) begin
                holdLeft--;
            end else if (creditRng[3:0] == 4'd0) begin
                holdLeft = int'(creditRng[7:4]);
            end
            if (holdLeft == 0 && owed > 0 && creditRng[9:8] != 2'd0) begin
                CreditReturn = 1'b1;
                owed--;
                returned++;
            end else begin
                CreditReturn = 1'b0;
            end
        end
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycles > timeoutLimit) begin
            $display("Timeout: no end of run within %0d cycles", timeoutLimit);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        int tableDws;
        tableDws = 0;
        for (int i = 0; i < NumRows; i++) begin
            tableDws += int'(StimTable[i][4:2]);
        end
        timeoutLimit    = NumPasses * tableDws * 4 + 200;
        RST             = 1'b1;
        Valid           = 1'b0;
        Data            = '0;
        DataEn          = '0;
        DataStartFlag   = 1'b0;
        DataStartOffset = '0;
        Done            = 1'b0;
        Err             = 1'b0;
        Tag             = '0;
        expErr          = '0;
        dataRng         = 32'd24;
        repeat (5) @(negedge CLK);
        RST = 1'b0;
        if (OutValid !== 1'b0) begin
            $display("ERROR OutValid after reset: expected %h, got %h", 1'b0, OutValid);
            setupErrs++;
        end
        for (int pass = 0; pass < NumPasses; pass++) begin
            expErr = '0;
            applyTable();
            while (tagsDone < NumTags * (pass + 1)) begin
                @(negedge CLK);
            end
            repeat (10) @(negedge CLK);  // Last tag clears before reuse
        end
        for (int t = 0; t < NumTags; t++) begin
            if (expQ[t].size() != 0) begin
                $display("Tag %0d still has %0d expected DWs unsent", t, expQ[t].size());
                setupErrs++;
            end
        end
        $display("Summary: %0d tag tests, %0d failed, %0d check errors, %0d credit errors",
                 tagsDone, testsFailed, checkErrs, creditErrs + setupErrs);
        if (testsFailed == 0 && checkErrs == 0 && creditErrs == 0 && setupErrs == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
